/* design/ack_ctrl_config.svh */
// widths fixed by the 802.11 frame format; COUNT_SCALE and NUM_CLK_PER_US hold sim values, hw sets them to the clock rate in MHz
`ifndef ACK_CTRL_CONFIG_SVH
`define ACK_CTRL_CONFIG_SVH

// address and counter widths
`define MAC_ADDR_W 48
`define TIMER_W 15
`define RETRY_W 4

// transmit buffer port
`define DINA_W 64
`define BRAM_ADDR_W 10

// clock cycles per microsecond unit of the time settings
`define COUNT_SCALE 2
`define NUM_CLK_PER_US 2

// ack/cts is 14 bytes, 6 ofdm symbols at 6 Mbps
`define ACK_SIGNAL_LEN 14
`define ACK_N_SYM 6

`endif

/* design/ack_ctrl_pkg.sv */
// shared types only; widths follow the config header
`include "ack_ctrl_config.svh"

package ack_ctrl_pkg;

  // control fsm states
  typedef enum logic [2:0] {
    IDLE,
    PREP_ACK,
    SEND_ACK,
    WAIT_TX_BB_DONE,
    WAIT_SIG_VALID,
    RECV_ACK
  } ctrl_state_e;

  // class of the received frame, from frame control and length
  typedef enum logic [2:0] {
    DATA,
    QOS_DATA,
    MGMT,
    PSPOLL,
    RTS,
    ACK,
    OTHER
  } frame_kind_e;

  typedef logic [`MAC_ADDR_W-1:0] mac_addr_t;
  typedef logic [`TIMER_W-1:0] timer_t;
  typedef logic [`RETRY_W-1:0] retry_t;

endpackage

/* design/rx_frame_decode.sv */
// inputs must hold the parsed fields of one frame; no block-ack or a-mpdu frames are recognised
`include "ack_ctrl_config.svh"

module rx_frame_decode (
  input  logic [1:0]                fc_type,
  input  logic [3:0]                fc_subtype,
  input  logic [15:0]               signal_len,
  input  logic                      fcs_valid,
  input  logic                      fcs_in_strobe,
  input  logic                      recv_ack_fcs_valid_disable,
  input  ack_ctrl_pkg::mac_addr_t   addr1,
  input  ack_ctrl_pkg::mac_addr_t   self_mac_addr,
  input  logic [1:0]                qos_ack_policy,
  input  logic                      cts_torts_disable,
  input  logic                      ack_tx_disable,
  output ack_ctrl_pkg::frame_kind_e frame_kind,
  output logic                      resp_req,
  output logic                      resp_cts,
  output logic                      ack_rcvd
);
  import ack_ctrl_pkg::*;

  logic addr_hit;
  logic eligible;

  // receiver address must be ours
  assign addr_hit = (addr1 == self_mac_addr);

  always_comb begin
    frame_kind = OTHER;
    if (fc_type == 2'b10) begin
      // subtype bit 3 marks qos data
      frame_kind = fc_subtype[3] ? QOS_DATA : DATA;
    end else if (fc_type == 2'b00) begin
      // action no ack gets no response
      if (fc_subtype != 4'b1110)
        frame_kind = MGMT;
    end else if (fc_type == 2'b01) begin
      // control frames, rts and ack also checked by length
      case (fc_subtype)
        4'b1010: frame_kind = PSPOLL;
        4'b1011: if (signal_len == 16'd20) frame_kind = RTS;
        4'b1101: if (signal_len == 16'(`ACK_SIGNAL_LEN)) frame_kind = ACK;
        default: frame_kind = OTHER;
      endcase
    end
  end

  // which classes expect an ack or cts back
  always_comb begin
    case (frame_kind)
      DATA, MGMT, PSPOLL: eligible = 1'b1;
      // only normal ack policy (00)
      QOS_DATA: eligible = (qos_ack_policy == 2'b00);
      RTS: eligible = !cts_torts_disable;
      default: eligible = 1'b0;
    endcase
  end

  assign resp_req = fcs_valid && addr_hit && !ack_tx_disable && eligible;
  assign resp_cts = (frame_kind == RTS);

  // fcs check on the ack can be bypassed
  assign ack_rcvd = (frame_kind == ACK) && addr_hit &&
                    (fcs_in_strobe || recv_ack_fcs_valid_disable);

endmodule

/* design/tx_ack_fsm.sv */
// single-frame exchanges only; time settings are scaled by COUNT_SCALE and truncated to TIMER_W bits
`include "ack_ctrl_config.svh"

module tx_ack_fsm (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   resp_req,
  input  logic                   ack_rcvd,
  input  logic                   tx_core_is_ongoing,
  input  logic                   phy_tx_done,
  input  logic                   cts_toself_bb_is_ongoing,
  input  logic                   tx_pkt_need_ack,
  input  logic                   pulse_tx_bb_end,
  input  logic                   sig_valid,
  input  logic [15:0]            signal_len,
  input  logic                   backoff_done,
  input  logic                   quit_retrans,
  input  logic [3:0]             max_num_retrans,
  input  ack_ctrl_pkg::retry_t   tx_pkt_retrans_limit,
  input  ack_ctrl_pkg::timer_t   send_ack_wait_top,
  input  ack_ctrl_pkg::timer_t   recv_ack_sig_valid_timeout_top,
  input  ack_ctrl_pkg::timer_t   recv_ack_timeout_top_adj,
  output logic                   capture,
  output logic                   in_send,
  output logic                   tx_control_state_idle,
  output logic                   ack_cts_is_ongoing,
  output logic                   retrans_in_progress,
  output logic                   start_retrans,
  output logic                   start_tx_ack,
  output logic                   retrans_trigger,
  output logic                   tx_try_complete,
  output logic [`RETRY_W:0]      tx_status
);
  import ack_ctrl_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  timer_t      timer;
  timer_t      wait_lock;
  timer_t      ack_top;
  timer_t      sig_top;
  retry_t      retry_cnt;
  retry_t      retry_limit;
  logic        retrans_started;
  logic        started_nxt;

  // events of the current cycle
  logic accept;
  logic own_done;
  logic quit;
  logic retry_go;
  logic go_send;
  logic sig_ok;
  logic ack_ok;
  logic timeout;
  logic give_up;
  logic acked;
  logic complete;
  logic retry;

  // bit 3 of max_num_retrans overrides the per-packet limit
  assign retry_limit = max_num_retrans[3] ? {1'b0, max_num_retrans[2:0]} : tx_pkt_retrans_limit;
  assign sig_top = timer_t'(recv_ack_sig_valid_timeout_top * `COUNT_SCALE);

  always_comb begin
    state_nxt = state;
    started_nxt = retrans_started;
    accept = 1'b0;
    own_done = 1'b0;
    quit = 1'b0;
    retry_go = 1'b0;
    go_send = 1'b0;
    sig_ok = 1'b0;
    ack_ok = 1'b0;
    timeout = 1'b0;
    case (state)
      IDLE: begin
        // response to a received frame wins over own traffic
        if (resp_req) begin
          accept = 1'b1;
          state_nxt = PREP_ACK;
        end else if (phy_tx_done && !cts_toself_bb_is_ongoing) begin
          own_done = 1'b1;
          started_nxt = 1'b0;
          if (tx_pkt_need_ack)
            state_nxt = WAIT_TX_BB_DONE;
        end else if (quit_retrans && retrans_in_progress) begin
          quit = 1'b1;
          started_nxt = 1'b0;
        end else if (backoff_done && retrans_in_progress && !retrans_started) begin
          retry_go = 1'b1;
          started_nxt = 1'b1;
        end
      end
      PREP_ACK: begin
        // first cycle is the capture cycle, the turnaround counts after it
        if (tx_core_is_ongoing) begin
          state_nxt = IDLE;
        end else if (!capture && timer == wait_lock) begin
          go_send = 1'b1;
          state_nxt = SEND_ACK;
        end
      end
      SEND_ACK: begin
        if (phy_tx_done)
          state_nxt = IDLE;
      end
      WAIT_TX_BB_DONE: begin
        if (pulse_tx_bb_end)
          state_nxt = WAIT_SIG_VALID;
      end
      WAIT_SIG_VALID: begin
        // only a 14 byte signal field can be our ack
        if (sig_valid && signal_len == 16'(`ACK_SIGNAL_LEN) && timer < sig_top) begin
          sig_ok = 1'b1;
          state_nxt = RECV_ACK;
        end else if (timer == sig_top) begin
          timeout = 1'b1;
          state_nxt = IDLE;
        end
      end
      RECV_ACK: begin
        if (ack_rcvd && timer < ack_top) begin
          ack_ok = 1'b1;
          state_nxt = IDLE;
        end else if (timer == ack_top) begin
          timeout = 1'b1;
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  // limit 0 means never retry
  assign give_up = timeout && (retry_cnt == retry_limit || retry_limit == '0);
  assign retry = timeout && !give_up;
  assign acked = ack_ok || (own_done && !tx_pkt_need_ack);
  assign complete = acked || give_up || quit;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= IDLE;
      timer <= '0;
      retry_cnt <= '0;
      retrans_started <= 1'b0;
      capture <= 1'b0;
      in_send <= 1'b0;
      tx_control_state_idle <= 1'b1;
      ack_cts_is_ongoing <= 1'b0;
      retrans_in_progress <= 1'b0;
      start_retrans <= 1'b0;
      start_tx_ack <= 1'b0;
      retrans_trigger <= 1'b0;
      tx_try_complete <= 1'b0;
      tx_status <= '0;
    end else begin
      state <= state_nxt;
      retrans_started <= started_nxt;
      // restart on every state change and during capture
      timer <= (state_nxt != state || capture) ? '0 : timer + 1'b1;
      capture <= accept;
      start_tx_ack <= go_send;
      start_retrans <= retry_go;
      retrans_trigger <= retry;
      tx_try_complete <= complete;
      in_send <= (state_nxt == SEND_ACK);
      ack_cts_is_ongoing <= (state_nxt == PREP_ACK) || (state_nxt == SEND_ACK);
      tx_control_state_idle <= (state_nxt == IDLE) && !started_nxt;
      if (own_done && tx_pkt_need_ack)
        retrans_in_progress <= 1'b1;
      else if (complete)
        retrans_in_progress <= 1'b0;
      // status: acked flag on top, retry count below
      if (complete) begin
        tx_status <= {acked, retry_cnt};
        retry_cnt <= '0;
      end else if (retry) begin
        retry_cnt <= retry_cnt + 1'b1;
      end
    end
  end

  // limits sampled at the start of each wait
  always_ff @(posedge clk) begin
    if (accept)
      wait_lock <= timer_t'(send_ack_wait_top * `COUNT_SCALE);
    if (sig_ok)
      ack_top <= timer_t'(`ACK_N_SYM * 4 * `NUM_CLK_PER_US +
                          recv_ack_timeout_top_adj * `COUNT_SCALE);
  end

  // tx core start is a single-cycle strobe
  a_start_one: assert property (@(posedge clk) disable iff (!rstn)
    start_tx_ack |=> !start_tx_ack);

  // a timeout either retries or gives up
  a_trig_vs_done: assert property (@(posedge clk) disable iff (!rstn)
    !(tx_try_complete && retrans_trigger));

endmodule

/* design/ack_frame_builder.sv */
// serves only buffer words 0, 2 and 3 of a 14 byte ack/cts; rate is taken as given, no rate fallback
`include "ack_ctrl_config.svh"

module ack_frame_builder (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      capture,
  input  logic                      in_send,
  input  logic                      resp_cts,
  input  ack_ctrl_pkg::frame_kind_e frame_kind,
  input  ack_ctrl_pkg::mac_addr_t   addr2,
  input  logic [15:0]               duration,
  input  logic                      fc_more_frag,
  input  logic [15:0]               duration_extra,
  input  logic [6:0]                preamble_sig_time,
  input  logic [4:0]                ofdm_symbol_time,
  input  logic [6:0]                sifs_time,
  input  logic [3:0]                cts_torts_rate,
  input  logic [`BRAM_ADDR_W-1:0]   bram_addr,
  output logic [`DINA_W-1:0]        dina
);
  import ack_ctrl_pkg::*;

  localparam logic [`BRAM_ADDR_W-1:0] ADDR_SIGNAL = 0;
  localparam logic [`BRAM_ADDR_W-1:0] ADDR_HDR = 2;
  localparam logic [`BRAM_ADDR_W-1:0] ADDR_RA_HI = 3;

  mac_addr_t          ra_lat;
  logic [14:0]        dur_lat;
  logic               frag_lat;
  logic               cts_lat;
  frame_kind_e        kind_lat;
  logic [9:0]         ack_air;
  logic signed [16:0] dur_std;
  logic               calc_dur;
  logic [15:0]        dur_rsp;

  // received frame fields; addr2 becomes the response RA
  always_ff @(posedge clk) begin
    if (capture) begin
      ra_lat <= addr2;
      // bit 15 set means an aid, not a duration
      dur_lat <= duration[15] ? 15'd0 : duration[14:0];
      frag_lat <= fc_more_frag;
      kind_lat <= frame_kind;
      cts_lat <= resp_cts;
    end
  end

  // airtime of the ack itself, preamble plus symbols
  assign ack_air = 10'(preamble_sig_time) + 10'(`ACK_N_SYM * ofdm_symbol_time);
  assign dur_std = $signed({2'b00, dur_lat}) - $signed({7'd0, ack_air}) -
                   $signed({10'd0, sifs_time});

  // only fragment bursts and rts carry the remaining duration on
  assign calc_dur = ((kind_lat == DATA || kind_lat == QOS_DATA || kind_lat == MGMT) &&
                     frag_lat) || cts_lat;
  // negative remainder clamps to 0
  assign dur_rsp = duration_extra + ((calc_dur && !dur_std[16]) ? dur_std[15:0] : 16'd0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dina <= '0;
    end else if (in_send) begin
      case (bram_addr)
        // signal field, parity is even over rate since length 14 has three ones
        ADDR_SIGNAL: dina <= {32'd0, 14'd0, ~^cts_torts_rate, 12'(`ACK_SIGNAL_LEN), 1'b0,
                              cts_torts_rate};
        // ra low, duration, frame control type 01
        ADDR_HDR: dina <= {ra_lat[31:0], dur_rsp, 8'd0, (cts_lat ? 4'b1100 : 4'b1101),
                           2'b01, 2'b00};
        ADDR_RA_HI: dina <= {48'd0, ra_lat[47:32]};
        default: dina <= dina;
      endcase
    end
  end

endmodule

/* design/tx_control.sv */
// top of the ack controller; received frame fields must stay stable until the cycle after resp_req
`include "ack_ctrl_config.svh"

module tx_control (
  input  logic                    clk,
  input  logic                    rstn,
  // received frame
  input  logic [1:0]              fc_type,
  input  logic [3:0]              fc_subtype,
  input  logic                    fc_more_frag,
  input  logic [15:0]             signal_len,
  input  logic                    sig_valid,
  input  logic                    fcs_valid,
  input  logic                    fcs_in_strobe,
  input  ack_ctrl_pkg::mac_addr_t addr1,
  input  ack_ctrl_pkg::mac_addr_t addr2,
  input  logic [15:0]             duration,
  input  logic [1:0]              qos_ack_policy,
  // configuration
  input  ack_ctrl_pkg::mac_addr_t self_mac_addr,
  input  logic                    ack_tx_disable,
  input  logic                    cts_torts_disable,
  input  logic [3:0]              cts_torts_rate,
  input  logic                    recv_ack_fcs_valid_disable,
  input  logic [15:0]             duration_extra,
  input  logic [6:0]              preamble_sig_time,
  input  logic [4:0]              ofdm_symbol_time,
  input  logic [6:0]              sifs_time,
  input  logic [3:0]              max_num_retrans,
  input  ack_ctrl_pkg::retry_t    tx_pkt_retrans_limit,
  input  ack_ctrl_pkg::timer_t    send_ack_wait_top,
  input  ack_ctrl_pkg::timer_t    recv_ack_sig_valid_timeout_top,
  input  ack_ctrl_pkg::timer_t    recv_ack_timeout_top_adj,
  // transmit path and csma
  input  logic                    tx_core_is_ongoing,
  input  logic                    phy_tx_done,
  input  logic                    cts_toself_bb_is_ongoing,
  input  logic                    tx_pkt_need_ack,
  input  logic                    pulse_tx_bb_end,
  input  logic                    backoff_done,
  input  logic                    quit_retrans,
  input  logic [`BRAM_ADDR_W-1:0] bram_addr,
  output logic                    tx_control_state_idle,
  output logic                    ack_cts_is_ongoing,
  output logic                    retrans_in_progress,
  output logic                    start_retrans,
  output logic                    start_tx_ack,
  output logic                    retrans_trigger,
  output logic                    tx_try_complete,
  output logic [`RETRY_W:0]       tx_status,
  output logic [`DINA_W-1:0]      dina
);
  import ack_ctrl_pkg::*;

  // decode to fsm and builder
  frame_kind_e frame_kind;
  logic        resp_req;
  logic        resp_cts;
  logic        ack_rcvd;
  // fsm to builder
  logic        capture;
  logic        in_send;

  rx_frame_decode u_decode (.*);

  tx_ack_fsm u_fsm (.*);

  ack_frame_builder u_builder (.*);

endmodule

/* verif/tb_tx_control.sv */
// checks single-frame exchanges only; turnaround and timeouts assume COUNT_SCALE from the config header
`include "ack_ctrl_config.svh"

module tb_tx_control;
  import ack_ctrl_pkg::*;

  // flags that wait_flag can poll
  localparam int SEL_START_TX_ACK = 0;
  localparam int SEL_ACK_BUSY = 1;
  localparam int SEL_RETRANS_IP = 2;
  localparam int SEL_TRIGGER = 3;
  localparam int SEL_START_RETRANS = 4;
  localparam int SEL_COMPLETE = 5;
  localparam int SEL_IDLE = 6;
  localparam int WAIT_LIMIT = 400;

  // station setup shared by all tests
  localparam mac_addr_t SELF_ADDR = 48'h0012_3456_789a;
  localparam logic [6:0] PRE_TIME = 7'd20;
  localparam logic [4:0] SYM_TIME = 5'd4;
  localparam logic [6:0] SIFS = 7'd16;
  localparam logic [3:0] RATE = 4'b1011;

  logic clk;
  logic rstn;
  logic [1:0] fc_type;
  logic [3:0] fc_subtype;
  logic fc_more_frag;
  logic [15:0] signal_len;
  logic sig_valid;
  logic fcs_valid;
  logic fcs_in_strobe;
  mac_addr_t addr1;
  mac_addr_t addr2;
  logic [15:0] duration;
  logic [1:0] qos_ack_policy;
  mac_addr_t self_mac_addr;
  logic ack_tx_disable;
  logic cts_torts_disable;
  logic [3:0] cts_torts_rate;
  logic recv_ack_fcs_valid_disable;
  logic [15:0] duration_extra;
  logic [6:0] preamble_sig_time;
  logic [4:0] ofdm_symbol_time;
  logic [6:0] sifs_time;
  logic [3:0] max_num_retrans;
  retry_t tx_pkt_retrans_limit;
  timer_t send_ack_wait_top;
  timer_t recv_ack_sig_valid_timeout_top;
  timer_t recv_ack_timeout_top_adj;
  logic tx_core_is_ongoing;
  logic phy_tx_done;
  logic cts_toself_bb_is_ongoing;
  logic tx_pkt_need_ack;
  logic pulse_tx_bb_end;
  logic backoff_done;
  logic quit_retrans;
  logic [`BRAM_ADDR_W-1:0] bram_addr;
  logic tx_control_state_idle;
  logic ack_cts_is_ongoing;
  logic retrans_in_progress;
  logic start_retrans;
  logic start_tx_ack;
  logic retrans_trigger;
  logic tx_try_complete;
  logic [`RETRY_W:0] tx_status;
  logic [`DINA_W-1:0] dina;

  // pending comparisons, drained by the checker
  string item_q[$];
  logic [63:0] exp_q[$];
  logic [63:0] act_q[$];
  string cur_test;
  int err_cnt = 0;
  int err_base = 0;
  int check_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int seed_rng;

  tx_control dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // checker, one pass per rising edge
  always @(posedge clk) begin
    string item;
    logic [63:0] exp_v;
    logic [63:0] act_v;
    while (act_q.size() != 0) begin
      item = item_q.pop_front();
      exp_v = exp_q.pop_front();
      act_v = act_q.pop_front();
      check_cnt++;
      assert (act_v === exp_v) else begin
        $display("CHECK FAILED %s expected %0h actual %0h", item, exp_v, act_v);
        err_cnt++;
      end
    end
  end

  // expected response duration
  function automatic logic [15:0] ref_duration(input logic [15:0] dur_in, input bit carry_on,
                                               input logic [15:0] extra);
    int remain;
    remain = 0;
    // bit 15 marks an aid, which counts as zero
    if (carry_on && !dur_in[15])
      remain = int'(dur_in) - (int'(PRE_TIME) + `ACK_N_SYM * int'(SYM_TIME)) - int'(SIFS);
    if (remain < 0)
      remain = 0;
    ref_duration = extra + 16'(remain);
  endfunction

  // expected buffer word of the ack/cts
  function automatic logic [63:0] ref_word(input int addr, input mac_addr_t ra,
                                           input logic [15:0] dur_rsp, input bit is_cts);
    logic [16:0] sig_low;
    logic [3:0] subtype;
    sig_low = {12'(`ACK_SIGNAL_LEN), 1'b0, RATE};
    subtype = is_cts ? 4'b1100 : 4'b1101;
    case (addr)
      // even parity over rate, reserved bit and length
      0: ref_word = {46'd0, ^sig_low, sig_low};
      2: ref_word = {ra[31:0], dur_rsp, 8'd0, subtype, 2'b01, 2'b00};
      3: ref_word = {48'd0, ra[47:32]};
      default: ref_word = 64'd0;
    endcase
  endfunction

  function automatic logic flag_value(input int sel);
    case (sel)
      SEL_START_TX_ACK: flag_value = start_tx_ack;
      SEL_ACK_BUSY: flag_value = ack_cts_is_ongoing;
      SEL_RETRANS_IP: flag_value = retrans_in_progress;
      SEL_TRIGGER: flag_value = retrans_trigger;
      SEL_START_RETRANS: flag_value = start_retrans;
      SEL_COMPLETE: flag_value = tx_try_complete;
      SEL_IDLE: flag_value = tx_control_state_idle;
      default: flag_value = 1'b0;
    endcase
  endfunction

  task automatic check_val(input string item, input logic [63:0] exp_v, input logic [63:0] act_v);
    item_q.push_back({cur_test, " ", item});
    exp_q.push_back(exp_v);
    act_q.push_back(act_v);
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok) else begin
      $display("%s: %s", cur_test, what);
      err_cnt++;
    end
  endtask

  // polls at falling edges, cycles counts the edges seen
  task automatic wait_flag(input int sel, input int limit, output int cycles, output bit seen);
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < limit) begin
      @(negedge clk);
      cycles++;
      seen = (flag_value(sel) === 1'b1);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_base = err_cnt;
  endtask

  task automatic end_test();
    int guard;
    guard = 0;
    while (act_q.size() != 0 && guard < 10) begin
      @(posedge clk);
      guard++;
    end
    @(negedge clk);
    check_true(act_q.size() == 0, "checker queue did not drain");
    if (err_cnt == err_base) begin
      pass_cnt++;
      $display("test %s: passed", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", cur_test, err_cnt - err_base);
    end
  endtask

  // fields stay one cycle past resp_req for the capture
  task automatic send_frame(input logic [1:0] ftype, input logic [3:0] fsub, input logic [15:0] len,
                            input mac_addr_t ra_to, input mac_addr_t ta, input logic [15:0] dur,
                            input logic frag);
    @(posedge clk);
    fc_type <= ftype;
    fc_subtype <= fsub;
    signal_len <= len;
    addr1 <= ra_to;
    addr2 <= ta;
    duration <= dur;
    fc_more_frag <= frag;
    fcs_valid <= 1'b1;
    // edge 0 of the turnaround
    @(posedge clk);
    fcs_valid <= 1'b0;
  endtask

  task automatic read_word(input int addr, output logic [63:0] word);
    @(posedge clk);
    bram_addr <= 10'(addr);
    @(posedge clk);
    @(negedge clk);
    word = dina;
  endtask

  task automatic end_send();
    int cycles;
    bit seen;
    @(posedge clk);
    phy_tx_done <= 1'b1;
    @(posedge clk);
    phy_tx_done <= 1'b0;
    wait_flag(SEL_IDLE, 20, cycles, seen);
    check_true(seen, "controller did not return to idle after the response");
  endtask

  task automatic check_response(input logic [15:0] dur, input mac_addr_t ta, input bit is_cts,
                                input bit carry_on, input logic [15:0] extra, input int n);
    int cycles;
    bit seen;
    logic [63:0] word;
    logic [15:0] exp_dur;
    wait_flag(SEL_START_TX_ACK, n + 20, cycles, seen);
    check_true(seen, "start_tx_ack never pulsed");
    // first poll shows edge 0
    check_val("turnaround edge", 64'(n + 2), 64'(cycles - 1));
    @(negedge clk);
    check_val("start_tx_ack width", 64'd0, 64'(start_tx_ack));
    exp_dur = ref_duration(dur, carry_on, extra);
    read_word(0, word);
    check_val("word 0", ref_word(0, ta, exp_dur, is_cts), word);
    read_word(2, word);
    check_val("word 2", ref_word(2, ta, exp_dur, is_cts), word);
    read_word(3, word);
    check_val("word 3", ref_word(3, ta, exp_dur, is_cts), word);
    end_send();
  endtask

  task automatic expect_silent(input int limit);
    int cycles;
    bit seen;
    wait_flag(SEL_ACK_BUSY, limit, cycles, seen);
    check_true(!seen, "response started for a frame that needs none");
  endtask

  task automatic own_tx_done();
    @(posedge clk);
    phy_tx_done <= 1'b1;
    @(posedge clk);
    phy_tx_done <= 1'b0;
  endtask

  task automatic bb_end();
    @(posedge clk);
    pulse_tx_bb_end <= 1'b1;
    @(posedge clk);
    pulse_tx_bb_end <= 1'b0;
  endtask

  task automatic sig_field(input logic [15:0] len);
    @(posedge clk);
    signal_len <= len;
    sig_valid <= 1'b1;
    @(posedge clk);
    sig_valid <= 1'b0;
  endtask

  // addressed ack with a good fcs
  task automatic ack_frame();
    @(posedge clk);
    fc_type <= 2'b01;
    fc_subtype <= 4'b1101;
    signal_len <= 16'(`ACK_SIGNAL_LEN);
    addr1 <= SELF_ADDR;
    fcs_in_strobe <= 1'b1;
    @(posedge clk);
    fcs_in_strobe <= 1'b0;
  endtask

  task automatic pulse_backoff();
    @(posedge clk);
    backoff_done <= 1'b1;
    @(posedge clk);
    backoff_done <= 1'b0;
  endtask

  task automatic pulse_quit();
    @(posedge clk);
    quit_retrans <= 1'b1;
    @(posedge clk);
    quit_retrans <= 1'b0;
  endtask

  initial begin
    int cycles;
    bit seen;
    int wait_top;
    logic [15:0] dur;
    logic [15:0] extra;
    mac_addr_t ta;
    seed_rng = $urandom(48);
    rstn <= 1'b0;
    fc_type <= 2'b11;
    fc_subtype <= 4'd0;
    fc_more_frag <= 1'b0;
    signal_len <= 16'd0;
    sig_valid <= 1'b0;
    fcs_valid <= 1'b0;
    fcs_in_strobe <= 1'b0;
    addr1 <= '0;
    addr2 <= '0;
    duration <= 16'd0;
    qos_ack_policy <= 2'b00;
    self_mac_addr <= SELF_ADDR;
    ack_tx_disable <= 1'b0;
    cts_torts_disable <= 1'b0;
    cts_torts_rate <= RATE;
    recv_ack_fcs_valid_disable <= 1'b0;
    duration_extra <= 16'd0;
    preamble_sig_time <= PRE_TIME;
    ofdm_symbol_time <= SYM_TIME;
    sifs_time <= SIFS;
    max_num_retrans <= 4'd0;
    tx_pkt_retrans_limit <= 4'd2;
    send_ack_wait_top <= 15'd1;
    recv_ack_sig_valid_timeout_top <= 15'd20;
    recv_ack_timeout_top_adj <= 15'd5;
    tx_core_is_ongoing <= 1'b0;
    phy_tx_done <= 1'b0;
    cts_toself_bb_is_ongoing <= 1'b0;
    tx_pkt_need_ack <= 1'b0;
    pulse_tx_bb_end <= 1'b0;
    backoff_done <= 1'b0;
    quit_retrans <= 1'b0;
    bram_addr <= '0;
    repeat (10) @(posedge clk);
    rstn <= 1'b1;

    start_test("reset_state");
    @(negedge clk);
    check_val("strobes", 64'd0,
              64'({start_tx_ack, start_retrans, retrans_trigger, tx_try_complete}));
    check_val("retrans_in_progress", 64'd0, 64'(retrans_in_progress));
    check_val("idle", 64'd1, 64'(tx_control_state_idle));
    check_val("tx_status", 64'd0, 64'(tx_status));
    end_test();

    start_test("ack_response");
    wait_top = $urandom_range(1, 5);
    extra = 16'($urandom_range(0, 50));
    dur = 16'($urandom_range(0, 300));
    ta = 48'({$urandom(), $urandom()});
    @(posedge clk);
    send_ack_wait_top <= 15'(wait_top);
    duration_extra <= extra;
    // data frame, more fragments to follow
    send_frame(2'b10, 4'b0000, 16'd60, SELF_ADDR, ta, dur, 1'b1);
    check_response(dur, ta, 1'b0, 1'b1, extra, wait_top * `COUNT_SCALE);
    send_frame(2'b10, 4'b0000, 16'd60, SELF_ADDR ^ 48'h1, ta, dur, 1'b1);
    expect_silent(40);
    @(posedge clk);
    ack_tx_disable <= 1'b1;
    send_frame(2'b10, 4'b0000, 16'd60, SELF_ADDR, ta, dur, 1'b1);
    expect_silent(40);
    @(posedge clk);
    ack_tx_disable <= 1'b0;
    end_test();

    start_test("cts_response");
    // short duration, the remainder clamps to zero
    send_frame(2'b01, 4'b1011, 16'd20, SELF_ADDR, ta, 16'd50, 1'b0);
    check_response(16'd50, ta, 1'b1, 1'b1, extra, wait_top * `COUNT_SCALE);
    @(posedge clk);
    cts_torts_disable <= 1'b1;
    send_frame(2'b01, 4'b1011, 16'd20, SELF_ADDR, ta, 16'd50, 1'b0);
    expect_silent(40);
    @(posedge clk);
    cts_torts_disable <= 1'b0;
    end_test();

    start_test("ack_received");
    @(posedge clk);
    tx_pkt_need_ack <= 1'b1;
    own_tx_done();
    wait_flag(SEL_RETRANS_IP, 10, cycles, seen);
    check_true(seen, "retrans_in_progress did not rise");
    bb_end();
    sig_field(16'(`ACK_SIGNAL_LEN));
    ack_frame();
    wait_flag(SEL_COMPLETE, 80, cycles, seen);
    check_true(seen, "tx_try_complete never pulsed");
    check_val("tx_status", 64'({1'b1, 4'd0}), 64'(tx_status));
    check_val("retrans_in_progress", 64'd0, 64'(retrans_in_progress));
    end_test();

    start_test("retry_give_up");
    for (int i = 0; i < 3; i++) begin
      own_tx_done();
      bb_end();
      // second try gets its signal field, then no ack
      if (i == 1)
        sig_field(16'(`ACK_SIGNAL_LEN));
      if (i < 2) begin
        wait_flag(SEL_TRIGGER, WAIT_LIMIT, cycles, seen);
        check_true(seen, "retrans_trigger did not rise after the timeout");
        check_val("complete at retry", 64'd0, 64'(tx_try_complete));
        pulse_backoff();
        wait_flag(SEL_START_RETRANS, 10, cycles, seen);
        check_true(seen, "start_retrans did not follow backoff_done");
      end else begin
        wait_flag(SEL_COMPLETE, WAIT_LIMIT, cycles, seen);
        check_true(seen, "no completion after the last timeout");
        check_val("tx_status", 64'({1'b0, 4'd2}), 64'(tx_status));
        check_val("retrans_in_progress", 64'd0, 64'(retrans_in_progress));
      end
    end
    end_test();

    start_test("quit_retry");
    own_tx_done();
    bb_end();
    wait_flag(SEL_TRIGGER, WAIT_LIMIT, cycles, seen);
    check_true(seen, "retrans_trigger did not rise before the quit");
    pulse_quit();
    wait_flag(SEL_COMPLETE, 10, cycles, seen);
    check_true(seen, "quit_retrans gave no completion");
    check_val("outcome", 64'd0, 64'(tx_status[4]));
    check_val("retry count", 64'd1, 64'(tx_status[3:0]));
    check_val("retrans_in_progress", 64'd0, 64'(retrans_in_progress));
    end_test();

    $display("summary: %0d passed, %0d failed, %0d checks, %0d errors",
             pass_cnt, fail_cnt, check_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+design
design/ack_ctrl_pkg.sv
design/rx_frame_decode.sv
design/tx_ack_fsm.sv
design/ack_frame_builder.sv
design/tx_control.sv
verif/tb_tx_control.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_tx_control
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
